/* hdl/cfg_base_snoop.sv */
// base address capture
// latches the pcie base once from a snooped configuration word

`timescale 1ns/10ps
`default_nettype none

module cfg_base_snoop (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire [pcie_rq_pkg::cfg_snoop_w-1:0]    cfg_snoop_data,
    output logic [pcie_rq_pkg::pcie_addr_w-1:0]   base_addr
);
    import pcie_rq_pkg::*;

    logic                  captured;  // set once, stays set until reset
    logic [cfg_base_w-1:0] base_lo;
    logic                  snoop_hit;

    // word qualifies when low bits clear and base dword non-zero
    assign snoop_hit = (cfg_snoop_data[cfg_zero_w-1:0] == '0)
                    && (cfg_snoop_data[cfg_base_lsb +: cfg_base_w] != '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            captured <= 1'b0;
            base_lo  <= '0;      // zero base until first capture
        end else if (snoop_hit && !captured) begin
            captured <= 1'b1;
            base_lo  <= cfg_snoop_data[cfg_base_lsb +: cfg_base_w];
        end
    end

    // upper half of the base always zero
    assign base_addr = {{(pcie_addr_w-cfg_base_w){1'b0}}, base_lo};

endmodule

`default_nettype wire

/* hdl/pcie_rq_bridge.sv */
// axi4-lite to pcie rq/rc bridge
// single qword reads and writes become one-beat rq tlps,
// rc completions come back as axi read data

`timescale 1ns/10ps
`default_nettype none

module pcie_rq_bridge #(
    parameter int fifo_addr_w = 5
) (
    input  wire                                   clk,
    input  wire                                   rst,

    // axi read address / data
    input  wire [pcie_rq_pkg::axi_addr_w-1:0]     s_axi_araddr,
    input  wire                                   s_axi_arvalid,
    output logic                                  s_axi_arready,
    output logic [pcie_rq_pkg::axi_data_w-1:0]    s_axi_rdata,
    output logic [1:0]                            s_axi_rresp,
    output logic                                  s_axi_rvalid,
    input  wire                                   s_axi_rready,

    // axi write address / data / response
    input  wire [pcie_rq_pkg::axi_addr_w-1:0]     s_axi_awaddr,
    input  wire                                   s_axi_awvalid,
    output logic                                  s_axi_awready,
    input  wire [pcie_rq_pkg::axi_data_w-1:0]     s_axi_wdata,
    input  wire                                   s_axi_wvalid,
    output logic                                  s_axi_wready,
    output logic [1:0]                            s_axi_bresp,
    output logic                                  s_axi_bvalid,
    input  wire                                   s_axi_bready,

    // rq stream out
    output logic [pcie_rq_pkg::rq_data_w-1:0]     m_axis_rq_tdata,
    output logic [pcie_rq_pkg::rq_keep_w-1:0]     m_axis_rq_tkeep,
    output logic                                  m_axis_rq_tlast,
    output logic [pcie_rq_pkg::rq_user_w-1:0]     m_axis_rq_tuser,
    output logic                                  m_axis_rq_tvalid,
    input  wire                                   m_axis_rq_tready,

    // rc stream in, keep/last/user not needed for single beat completions
    input  wire [pcie_rq_pkg::rq_data_w-1:0]      s_axis_rc_tdata,
    input  wire [pcie_rq_pkg::rq_keep_w-1:0]      s_axis_rc_tkeep,
    input  wire                                   s_axis_rc_tlast,
    input  wire [pcie_rq_pkg::rc_user_w-1:0]      s_axis_rc_tuser,
    input  wire                                   s_axis_rc_tvalid,
    output logic                                  s_axis_rc_tready,

    input  wire [pcie_rq_pkg::cfg_snoop_w-1:0]    cfg_snoop_data
);
    import pcie_rq_pkg::*;

    logic [pcie_addr_w-1:0] base_addr;

    rq_beat_if rq_beat ();  // builder -> fifo

    cfg_base_snoop u_snoop (
        .clk            (clk),
        .rst            (rst),
        .cfg_snoop_data (cfg_snoop_data),
        .base_addr      (base_addr)
    );

    rq_tlp_builder u_builder (
        .clk       (clk),
        .rst       (rst),
        .base_addr (base_addr),
        .araddr    (s_axi_araddr),
        .arvalid   (s_axi_arvalid),
        .arready   (s_axi_arready),
        .awaddr    (s_axi_awaddr),
        .awvalid   (s_axi_awvalid),
        .awready   (s_axi_awready),
        .wdata     (s_axi_wdata),
        .wvalid    (s_axi_wvalid),
        .wready    (s_axi_wready),
        .bresp     (s_axi_bresp),
        .bvalid    (s_axi_bvalid),
        .bready    (s_axi_bready),
        .rq        (rq_beat.src)
    );

    rq_out_fifo #(
        .fifo_addr_w (fifo_addr_w)
    ) u_fifo (
        .clk    (clk),
        .rst    (rst),
        .rq     (rq_beat.snk),
        .tdata  (m_axis_rq_tdata),
        .tkeep  (m_axis_rq_tkeep),
        .tlast  (m_axis_rq_tlast),
        .tuser  (m_axis_rq_tuser),
        .tvalid (m_axis_rq_tvalid),
        .tready (m_axis_rq_tready)
    );

    rc_read_return u_rc (
        .clk       (clk),
        .rst       (rst),
        .rc_tdata  (s_axis_rc_tdata),
        .rc_tvalid (s_axis_rc_tvalid),
        .rc_tready (s_axis_rc_tready),
        .rdata     (s_axi_rdata),
        .rresp     (s_axi_rresp),
        .rvalid    (s_axi_rvalid),
        .rready    (s_axi_rready)
    );

endmodule

`default_nettype wire

/* hdl/pcie_rq_pkg.sv */
// pcie rq bridge shared definitions
// beat widths, request codes, header and sideband field positions

`default_nettype none

package pcie_rq_pkg;

    // stream widths
    localparam int rq_data_w = 256;            // fixed beat width
    localparam int rq_keep_w = rq_data_w / 32; // one bit per dword
    localparam int rq_user_w = 60;             // rq sideband at 256 bits
    localparam int rc_user_w = 75;             // rc sideband at 256 bits

    // axi4-lite side
    localparam int axi_addr_w = 40;
    localparam int axi_data_w = 64;

    // snooped configuration word
    localparam int cfg_snoop_w = 128;
    localparam int cfg_zero_w = 7;     // low bits that must be clear
    localparam int cfg_base_lsb = 96;  // base address lives in the top dword
    localparam int cfg_base_w = 32;

    // pcie address and base merge point
    localparam int pcie_addr_w = 64;
    localparam int base_keep_lsb = 16; // axi supplies the bits below

    // request header layout, descriptor style
    localparam int hdr_w = 128;
    localparam int hdr_dwc_lsb = 64;   // dword count
    localparam int hdr_dwc_w = 11;
    localparam int hdr_type_lsb = 75;  // request type
    localparam int hdr_type_w = 4;
    localparam int hdr_tag_lsb = 96;
    localparam int hdr_tag_w = 8;

    // request types
    localparam logic [hdr_type_w-1:0] req_mem_read = 4'd0;
    localparam logic [hdr_type_w-1:0] req_mem_write = 4'd1;

    // fixed header values
    localparam logic [hdr_dwc_w-1:0] req_dword_count = 11'd2; // one qword
    localparam logic [3:0] rd_tag_prefix = 4'hf;              // reads tagged f0..ff

    // keep per request kind
    localparam logic [rq_keep_w-1:0] keep_rd = 8'h0f;  // header only
    localparam logic [rq_keep_w-1:0] keep_wr = 8'h3f;  // header plus qword

    // rq sideband byte enables
    localparam int usr_first_be_lsb = 0;
    localparam int usr_last_be_lsb = 4;
    localparam logic [3:0] be_all = 4'hf;

    // axi responses
    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // completion fields on the rc beat
    localparam int rc_payload_lsb = 96; // first data qword after descriptor
    localparam int rc_status_lsb = 43;
    localparam int rc_status_w = 3;

endpackage

`default_nettype wire

/* hdl/rc_read_return.sv */
// completion to axi read data
// takes the first payload qword of an rc beat, flags bad status as slverr

`timescale 1ns/10ps
`default_nettype none

module rc_read_return (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire [pcie_rq_pkg::rq_data_w-1:0]      rc_tdata,
    input  wire                                   rc_tvalid,
    output logic                                  rc_tready,
    output logic [pcie_rq_pkg::axi_data_w-1:0]    rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  wire                                   rready
);
    import pcie_rq_pkg::*;

    logic                   take;
    logic [rc_status_w-1:0] cpl_status;

    assign cpl_status = rc_tdata[rc_status_lsb +: rc_status_w];

    // one completion in flight toward axi
    assign rc_tready = !rvalid;
    assign take = rc_tvalid && !rvalid;

    // payload, loaded only on take
    always_ff @(posedge clk) begin
        if (take) begin
            rdata <= rc_tdata[rc_payload_lsb +: axi_data_w];
            rresp <= (cpl_status != '0) ? resp_slverr : resp_okay;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rvalid <= 1'b0;
        end else if (take) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;  // held until axi master takes it
        end
    end

endmodule

`default_nettype wire

/* hdl/rq_beat_if.sv */
// one rq tlp beat with valid/ready handshake
// links the request builder to the output fifo

`timescale 1ns/10ps
`default_nettype none

interface rq_beat_if;
    import pcie_rq_pkg::*;

    logic [rq_data_w-1:0] data;
    logic [rq_keep_w-1:0] keep;  // dword keep
    logic                 last;
    logic [rq_user_w-1:0] user;  // rq sideband
    logic                 valid;
    logic                 ready; // from fifo, not half full

    // builder side
    modport src (
        output data, keep, last, user, valid,
        input  ready
    );

    // fifo side
    modport snk (
        input  data, keep, last, user, valid,
        output ready
    );

endinterface

`default_nettype wire

/* hdl/rq_out_fifo.sv */
// rq output fifo
// pointer based beat buffer with late half-full back-pressure
// and a registered rq output stage

`timescale 1ns/10ps
`default_nettype none

module rq_out_fifo #(
    parameter int fifo_addr_w = 5
) (
    input  wire                                   clk,
    input  wire                                   rst,
    rq_beat_if.snk                                rq,
    output logic [pcie_rq_pkg::rq_data_w-1:0]     tdata,
    output logic [pcie_rq_pkg::rq_keep_w-1:0]     tkeep,
    output logic                                  tlast,
    output logic [pcie_rq_pkg::rq_user_w-1:0]     tuser,
    output logic                                  tvalid,
    input  wire                                   tready
);
    import pcie_rq_pkg::*;

    localparam int depth = 2 ** fifo_addr_w;
    localparam int entry_w = rq_user_w + 1 + rq_keep_w + rq_data_w;

    logic [entry_w-1:0]   mem [depth];
    logic [fifo_addr_w:0] wr_ptr;  // extra msb tells full from empty
    logic [fifo_addr_w:0] rd_ptr;
    logic [fifo_addr_w:0] fill;
    logic                 half_full;
    logic                 empty;
    logic                 push;
    logic                 pop;

    assign fill  = wr_ptr - rd_ptr;
    assign empty = wr_ptr == rd_ptr;

    // flag lags a cycle, so stop well before full
    assign rq.ready = !half_full;
    assign push = rq.valid && rq.ready;
    // reload output when it is empty or being taken
    assign pop = !empty && (!tvalid || tready);

    // beat storage and output register
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[fifo_addr_w-1:0]] <= {rq.user, rq.last, rq.keep, rq.data};
        end
        if (pop) begin
            {tuser, tlast, tkeep, tdata} <= mem[rd_ptr[fifo_addr_w-1:0]];
        end
    end

    // pointers, flag, output valid
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            half_full <= 1'b0;
            tvalid    <= 1'b0;
        end else begin
            half_full <= fill >= (fifo_addr_w+1)'(depth / 2);
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                tvalid <= 1'b1;
            end else if (tready) begin
                tvalid <= 1'b0;  // taken with nothing behind it
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/rq_tlp_builder.sv */
// rq request builder
// arbitrates axi4-lite reads and writes into one-beat mem rd/wr tlps,
// keeps the read tag counter and the write response

`timescale 1ns/10ps
`default_nettype none

module rq_tlp_builder (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire [pcie_rq_pkg::pcie_addr_w-1:0]    base_addr,

    // read address
    input  wire [pcie_rq_pkg::axi_addr_w-1:0]     araddr,
    input  wire                                   arvalid,
    output logic                                  arready,

    // write address and data
    input  wire [pcie_rq_pkg::axi_addr_w-1:0]     awaddr,
    input  wire                                   awvalid,
    output logic                                  awready,
    input  wire [pcie_rq_pkg::axi_data_w-1:0]     wdata,
    input  wire                                   wvalid,
    output logic                                  wready,

    // write response
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  wire                                   bready,

    rq_beat_if.src                                rq
);
    import pcie_rq_pkg::*;

    logic                  rd_sel;   // read wins whenever offered
    logic                  wr_req;
    logic                  rd_go;
    logic                  wr_go;
    logic [3:0]            tag_cnt;  // rolling read tag, low nibble
    logic                  bvalid_q;
    logic [axi_addr_w-1:0] req_addr;
    logic [hdr_w-1:0]      hdr;
    logic [rq_user_w-1:0]  user;

    assign rd_sel = arvalid;
    // write needs both channels and a free response slot
    assign wr_req = awvalid && wvalid && !bvalid_q;

    assign rd_go = rd_sel && rq.ready;
    assign wr_go = !rd_sel && wr_req && rq.ready;

    assign arready = rd_go;
    assign awready = wr_go;  // aw and w taken together
    assign wready  = wr_go;

    assign req_addr = rd_sel ? araddr : awaddr;

    // request header
    always_comb begin
        hdr = '0;  // poisoned, req id, completer id, tc, attr all zero
        // base above the keep point, axi offset below
        hdr[pcie_addr_w-1:0] = {base_addr[pcie_addr_w-1:base_keep_lsb],
                                req_addr[base_keep_lsb-1:0]};
        hdr[hdr_dwc_lsb +: hdr_dwc_w] = req_dword_count;
        if (rd_sel) begin
            hdr[hdr_type_lsb +: hdr_type_w] = req_mem_read;
            hdr[hdr_tag_lsb +: hdr_tag_w] = {rd_tag_prefix, tag_cnt};
        end else begin
            hdr[hdr_type_lsb +: hdr_type_w] = req_mem_write;
            hdr[hdr_tag_lsb +: hdr_tag_w] = '0;  // posted, no tag
        end
    end

    // sideband, only byte enables used
    always_comb begin
        user = '0;
        user[usr_first_be_lsb +: 4] = be_all;  // first be
        user[usr_last_be_lsb +: 4] = be_all;   // last be
    end

    // beat assembly
    always_comb begin
        if (rd_sel) begin
            rq.data = {{(rq_data_w-hdr_w){1'b0}}, hdr};
            rq.keep = keep_rd;
        end else begin
            // write qword right after the header
            rq.data = {{(rq_data_w-hdr_w-axi_data_w){1'b0}}, wdata, hdr};
            rq.keep = keep_wr;
        end
    end

    assign rq.valid = rd_sel || wr_req;
    assign rq.last  = 1'b1;  // always single beat
    assign rq.user  = user;

    always_ff @(posedge clk) begin
        if (!rst) begin
            tag_cnt  <= '0;
            bvalid_q <= 1'b0;
        end else begin
            if (rd_go) begin
                tag_cnt <= tag_cnt + 4'd1;  // wraps f -> 0
            end
            if (wr_go) begin
                bvalid_q <= 1'b1;  // response on the accepting edge
            end else if (bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    assign bvalid = bvalid_q;
    assign bresp  = resp_okay;  // writes never fail here

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the rq bridge testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pcie_rq_bridge \
    -f tb.f -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1 || echo "build or run stopped early"
cat sim.log 2>/dev/null
grep -qF "*** TEST FAILED ***" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

/* tb.f */
hdl/pcie_rq_pkg.sv
hdl/rq_beat_if.sv
hdl/cfg_base_snoop.sv
hdl/rq_tlp_builder.sv
hdl/rq_out_fifo.sv
hdl/rc_read_return.sv
hdl/pcie_rq_bridge.sv
testbench/tb_pcie_rq_bridge_assert.sv
testbench/tb_pcie_rq_bridge.sv

/* testbench/tb_pcie_rq_bridge.sv */
// testbench for the axi4-lite to pcie rq/rc bridge
// random axi traffic and rq back-pressure, a completion for every read tlp,
// queue model predicts each rq beat and each read response

`timescale 1ns/10ps
`default_nettype none

module tb_pcie_rq_bridge;
    logic         clk = 1'b0;
    logic         rst;
    logic [39:0]  araddr;
    logic [39:0]  awaddr;
    logic [63:0]  wdata;
    logic         arvalid;
    logic         awvalid;
    logic         wvalid;
    logic         bready;
    logic         rready;
    logic         tready;
    logic [255:0] rc_tdata;
    logic         rc_tvalid;
    logic [127:0] cfg_snoop_data;
    wire          arready;
    wire          awready;
    wire          wready;
    wire          bvalid;
    wire          rvalid;
    wire          tvalid;
    wire          tlast;
    wire          rc_tready;
    wire  [1:0]   bresp;
    wire  [1:0]   rresp;
    wire  [63:0]  rdata;
    wire  [255:0] tdata;
    wire  [7:0]   tkeep;
    wire  [59:0]  tuser;

    int           seed = 27517;
    int           errors = 0;
    int           n_rd = 0;
    int           n_wr = 0;
    int           n_b = 0;
    int           n_beat = 0;
    int           n_cpl = 0;
    int           cpl_owed = 0;   // read tlps seen on rq and not yet answered
    int           wait_cyc;
    logic [31:0]  base_a;
    logic [31:0]  base_b;
    logic [31:0]  rnd;
    logic [15:0]  cyc = 16'd0;
    logic [3:0]   tag_cnt = 4'h0; // model of the rolling read tag
    logic [255:0] cpl;
    logic [255:0] e_data;
    logic [7:0]   e_keep;
    logic         e_last;
    logic [59:0]  e_user;
    logic [324:0] beat_q[$];      // {data, keep, last, user}
    logic [64:0]  r_q[$];         // {bad status, payload qword}
    logic [64:0]  e_r;
    logic         ar_hs = 1'b0;
    logic         aw_hs = 1'b0;
    logic         rc_hs = 1'b0;
    logic         exp_bvalid = 1'b0;
    logic         bp_seen = 1'b0; // read stalled by fifo half full
    logic         stim_on = 1'b0;
    logic         drain = 1'b0;
    logic         idle;

    pcie_rq_bridge #(
        .fifo_addr_w (5)
    ) DUT (
        .clk              (clk),
        .rst              (rst),
        .s_axi_araddr     (araddr),
        .s_axi_arvalid    (arvalid),
        .s_axi_arready    (arready),
        .s_axi_rdata      (rdata),
        .s_axi_rresp      (rresp),
        .s_axi_rvalid     (rvalid),
        .s_axi_rready     (rready),
        .s_axi_awaddr     (awaddr),
        .s_axi_awvalid    (awvalid),
        .s_axi_awready    (awready),
        .s_axi_wdata      (wdata),
        .s_axi_wvalid     (wvalid),
        .s_axi_wready     (wready),
        .s_axi_bresp      (bresp),
        .s_axi_bvalid     (bvalid),
        .s_axi_bready     (bready),
        .m_axis_rq_tdata  (tdata),
        .m_axis_rq_tkeep  (tkeep),
        .m_axis_rq_tlast  (tlast),
        .m_axis_rq_tuser  (tuser),
        .m_axis_rq_tvalid (tvalid),
        .m_axis_rq_tready (tready),
        .s_axis_rc_tdata  (rc_tdata),
        .s_axis_rc_tkeep  (8'hff),
        .s_axis_rc_tlast  (1'b1),
        .s_axis_rc_tuser  (75'h0),
        .s_axis_rc_tvalid (rc_tvalid),
        .s_axis_rc_tready (rc_tready),
        .cfg_snoop_data   (cfg_snoop_data)
    );

    always #50 clk = ~clk;  // 100 ns period

    // expected request header with the first snooped base merged in
    function automatic logic [127:0] make_hdr(input logic [39:0] addr,
                                              input logic [3:0] typ,
                                              input logic [7:0] tag);
        logic [127:0] h;
        h = '0;
        h[63:0]   = {32'h0, base_a[31:16], addr[15:0]};
        h[74:64]  = 11'd2;  // one qword
        h[78:75]  = typ;
        h[103:96] = tag;
        return h;
    endfunction

    // new requests only after the previous one was taken
    always @(posedge clk) begin
        if (rst) begin
            cyc <= cyc + 16'd1;
            rnd = $random(seed);
            if (!arvalid || ar_hs) begin
                arvalid <= stim_on && rnd[0];
                araddr  <= {rnd[15:8], $random(seed)};
            end
            if (!awvalid || aw_hs) begin
                awvalid <= stim_on && rnd[1];  // aw and w offered together
                wvalid  <= stim_on && rnd[1];
                awaddr  <= {rnd[23:16], $random(seed)};
                wdata   <= {$random(seed), $random(seed)};
            end
            // slow phases let the fifo pass half full
            tready <= drain || (cyc[9] ? rnd[2] : (rnd[4:2] == 3'b000));
            bready <= drain || rnd[5];
            rready <= drain || rnd[6];
            if (!rc_tvalid || rc_hs) begin
                if (cpl_owed > 0 && (drain || rnd[7])) begin
                    for (int i = 0; i < 8; i++) begin
                        cpl[i*32 +: 32] = $random(seed);
                    end
                    cpl[45:43] = (rnd[9:8] == 2'b00) ? rnd[12:10] : 3'b000; // status
                    rc_tdata  <= cpl;
                    rc_tvalid <= 1'b1;
                    cpl_owed  = cpl_owed - 1;
                end else begin
                    rc_tvalid <= 1'b0;
                end
            end
        end
    end

    // model and checks sampled mid cycle
    always @(negedge clk) begin
        ar_hs = arvalid && arready;
        aw_hs = awvalid && awready;
        rc_hs = rc_tvalid && rc_tready;
        if (rst) begin
            if (ar_hs) begin
                beat_q.push_back({128'h0, make_hdr(araddr, 4'h0, {4'hf, tag_cnt}),
                                  8'h0f, 1'b1, 60'hff});
                tag_cnt = tag_cnt + 4'd1;
                n_rd++;
            end
            if (arvalid && !arready) begin
                bp_seen = 1'b1;
            end
            if (aw_hs) begin
                if (arvalid || !wready) begin
                    errors++;
                    $display("write taken at %0t while a read was offered or w not ready",
                             $time);
                end
                beat_q.push_back({64'h0, wdata, make_hdr(awaddr, 4'h1, 8'h00),
                                  8'h3f, 1'b1, 60'hff});
                n_wr++;
            end
            if (bvalid !== exp_bvalid) begin
                errors++;
                $display("ERR %0t s_axi_bvalid got %b exp %b", $time, bvalid, exp_bvalid);
            end
            if (bvalid && bresp !== 2'b00) begin
                errors++;
                $display("ERR %0t s_axi_bresp got %b exp 00", $time, bresp);
            end
            n_b += (bvalid && bready) ? 1 : 0;
            exp_bvalid = aw_hs || (exp_bvalid && !bready);
            if (tvalid && tready) begin
                if (beat_q.size() == 0) begin
                    errors++;
                    $display("rq beat at %0t with no request accepted for it", $time);
                end else begin
                    {e_data, e_keep, e_last, e_user} = beat_q.pop_front();
                    n_beat++;
                    if (tdata !== e_data) begin
                        errors++;
                        $display("ERR %0t m_axis_rq_tdata got %h exp %h", $time, tdata, e_data);
                    end
                    if (tkeep !== e_keep) begin
                        errors++;
                        $display("ERR %0t m_axis_rq_tkeep got %h exp %h", $time, tkeep, e_keep);
                    end
                    if (tlast !== e_last) begin
                        errors++;
                        $display("ERR %0t m_axis_rq_tlast got %b exp %b", $time, tlast, e_last);
                    end
                    if (tuser !== e_user) begin
                        errors++;
                        $display("ERR %0t m_axis_rq_tuser got %h exp %h", $time, tuser, e_user);
                    end
                    if (e_keep == 8'h0f) begin
                        cpl_owed++;  // read tlp owes a completion
                    end
                end
            end
            if (rc_hs) begin
                r_q.push_back({rc_tdata[45:43] != 3'b000, rc_tdata[159:96]});
            end
            if (rvalid && rready) begin
                if (r_q.size() == 0) begin
                    errors++;
                    $display("read response at %0t with no completion sent", $time);
                end else begin
                    e_r = r_q.pop_front();
                    n_cpl++;
                    if (rdata !== e_r[63:0]) begin
                        errors++;
                        $display("ERR %0t s_axi_rdata got %h exp %h", $time, rdata, e_r[63:0]);
                    end
                    if (rresp !== (e_r[64] ? 2'b10 : 2'b00)) begin
                        errors++;
                        $display("ERR %0t s_axi_rresp got %b exp %b", $time, rresp,
                                 e_r[64] ? 2'b10 : 2'b00);
                    end
                end
            end
        end
    end

    initial begin
        base_a = $random(seed) | 32'h0001_0000;  // never zero
        base_b = base_a ^ 32'h5a5a_0000;         // later word to be ignored
        rst = 1'b0;
        arvalid = 1'b0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        araddr = '0;
        awaddr = '0;
        wdata = '0;
        bready = 1'b0;
        rready = 1'b0;
        tready = 1'b0;
        rc_tdata = '0;
        rc_tvalid = 1'b0;
        cfg_snoop_data = {base_a, 96'h0};  // low 7 bits clear
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        stim_on <= 1'b1;
        repeat (300) @(posedge clk);
        cfg_snoop_data <= {base_b, 96'h0};
        repeat (3000) @(posedge clk);
        stim_on <= 1'b0;
        drain <= 1'b1;
        wait_cyc = 0;
        idle = 1'b0;
        while (!idle && wait_cyc < 4000) begin
            @(negedge clk);
            wait_cyc++;
            idle = beat_q.size() == 0 && r_q.size() == 0 && cpl_owed == 0 && !arvalid
                && !awvalid && !bvalid && !rvalid && !rc_tvalid && !tvalid;
        end
        if (!idle) begin
            errors++;
            $display("timeout after %0d cycles, traffic did not drain", wait_cyc);
        end
        if (!bp_seen) begin
            errors++;
            $display("fifo never pushed back on the read channel");
        end
        if (n_b != n_wr) begin
            errors++;
            $display("ERR %0t s_axi_bvalid count got %0d exp %0d", $time, n_b, n_wr);
        end
        $display("errors %0d reads %0d writes %0d bresp %0d rq beats %0d completions %0d",
                 errors, n_rd, n_wr, n_b, n_beat, n_cpl);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_pcie_rq_bridge_assert.sv */
// protocol assertions on the rq bridge top level
// attached to every pcie_rq_bridge instance by bind

`timescale 1ns/10ps
`default_nettype none

module tb_pcie_rq_bridge_assert (
    input wire         clk,
    input wire         rst,
    input wire         tvalid,
    input wire         tready,
    input wire [255:0] tdata,
    input wire [7:0]   tkeep,
    input wire         tlast,
    input wire [59:0]  tuser,
    input wire         arready,
    input wire         awready,
    input wire         wready,
    input wire         bvalid
);
    // stalled beat stays put
    a_rq_hold: assert property (@(posedge clk) disable iff (!rst)
        tvalid && !tready |=> tvalid && $stable({tdata, tkeep, tlast, tuser}))
        else $error("rq beat changed while stalled");

    a_one_req: assert property (@(posedge clk) disable iff (!rst)
        !(arready && awready))
        else $error("read and write accepted together");

    a_w_vs_b: assert property (@(posedge clk) disable iff (!rst)
        !(wready && bvalid))
        else $error("write accepted with a response outstanding");

    a_rst_idle: assert property (@(posedge clk) !rst |=> !tvalid)
        else $error("rq tvalid high after reset");
endmodule

bind pcie_rq_bridge tb_pcie_rq_bridge_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .tvalid  (m_axis_rq_tvalid),
    .tready  (m_axis_rq_tready),
    .tdata   (m_axis_rq_tdata),
    .tkeep   (m_axis_rq_tkeep),
    .tlast   (m_axis_rq_tlast),
    .tuser   (m_axis_rq_tuser),
    .arready (s_axi_arready),
    .awready (s_axi_awready),
    .wready  (s_axi_wready),
    .bvalid  (s_axi_bvalid)
);

`default_nettype wire
